/* corr_ctrl.f */
src/cmd_pkg.sv
src/line_pkg.sv
src/cfg_wr_if.sv
src/cmd_parser.sv
src/level_bank.sv
src/delay_bank.sv
src/line_readback.sv
src/corr_ctrl.sv
tb/tb_corr_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for a failure.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_corr_ctrl -f corr_ctrl.f \
	-o tb_corr_ctrl > build.log 2>&1 \
	&& ./obj_dir/tb_corr_ctrl > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or run did not complete"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; } \
	|| echo "Simulation finished without failure"
exit 0

/* tb/tb_corr_ctrl.sv */
// Correlator control testbench
`default_nettype none

module tb_corr_ctrl;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_LINES  = 4;
	localparam int HAS_LEDS   = 1;
	localparam int SEED       = 32'h03f3_9806;
	localparam int MAX_CYCLES = 20000; // The tests take about 2600 cycles

	logic                 clk;
	logic                 rst_n;
	logic [7:0]           cmd;
	logic                 cmd_valid;
	logic [7:0]           read_line;
	logic [7:0]           current_line;
	logic [2:0]           baud_rate;
	logic [3:0]           order;
	logic                 integrating;
	logic                 external_clock;
	logic                 timestamp_reset;
	logic                 extra_commands;
	logic [NUM_LINES-1:0] pwm_out;
	logic [7:0]           rd_voltage;
	logic [7:0]           rd_test;
	logic [7:0]           rd_leds;
	logic [19:0]          rd_cross_idx;
	logic [19:0]          rd_auto_idx;
	logic [19:0]          rd_cross_len;
	logic [19:0]          rd_auto_len;
	logic [11:0]          rd_cross_inc;
	logic [11:0]          rd_auto_inc;

	// Reference model state
	logic [7:0]  m_line;
	logic [2:0]  m_baud;
	logic [3:0]  m_order;
	logic        m_integ;
	logic        m_ext_clk;
	logic        m_ts_rst;
	logic        m_extra;
	logic [7:0]  m_voltage [NUM_LINES];
	logic [7:0]  m_test [NUM_LINES];
	logic [7:0]  m_leds [NUM_LINES];
	logic [19:0] m_cross_idx [NUM_LINES];
	logic [19:0] m_auto_idx [NUM_LINES];
	logic [19:0] m_cross_len [NUM_LINES];
	logic [19:0] m_auto_len [NUM_LINES];
	logic [11:0] m_cross_inc [NUM_LINES];
	logic [11:0] m_auto_inc [NUM_LINES];

	logic [1:0] pend_valid; // Bytes on their way to the global registers
	logic [7:0] pend_byte [2];
	int         errors;
	int         checks_done;
	int         errs_at_start;
	int         cycle_count;

	corr_ctrl #(.NUM_LINES(NUM_LINES), .HAS_LEDS(HAS_LEDS)) dut0 (
		.clk             (clk),
		.rst_n           (rst_n),
		.cmd             (cmd),
		.cmd_valid       (cmd_valid),
		.read_line       (read_line),
		.current_line    (current_line),
		.baud_rate       (baud_rate),
		.order           (order),
		.integrating     (integrating),
		.external_clock  (external_clock),
		.timestamp_reset (timestamp_reset),
		.extra_commands  (extra_commands),
		.pwm_out         (pwm_out),
		.rd_voltage      (rd_voltage),
		.rd_test         (rd_test),
		.rd_leds         (rd_leds),
		.rd_cross_idx    (rd_cross_idx),
		.rd_auto_idx     (rd_auto_idx),
		.rd_cross_len    (rd_cross_len),
		.rd_auto_len     (rd_auto_len),
		.rd_cross_inc    (rd_cross_inc),
		.rd_auto_inc     (rd_auto_inc)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checking and model

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks_done++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	task automatic model_reset();
		m_line    = '0;
		m_baud    = '0;
		m_order   = '0;
		m_integ   = 1'b0;
		m_ext_clk = 1'b0;
		m_ts_rst  = 1'b1;
		m_extra   = 1'b0;
		for (int i = 0; i < NUM_LINES; i++) begin
			m_voltage[i]   = '0;
			m_test[i]      = '0;
			m_leds[i]      = '0;
			m_cross_idx[i] = '0;
			m_auto_idx[i]  = '0;
			m_cross_len[i] = '0;
			m_auto_len[i]  = '0;
			m_cross_inc[i] = 12'd1;
			m_auto_inc[i]  = 12'd1;
		end
	endtask

	task automatic model_line_write(input int ln, input logic [3:0] op, input logic [3:0] p,
			input logic ex);
		int slot;
		int hb;
		slot = 3 * int'(op[1:0]);
		hb = 12 + 2 * int'(p[2]);
		case (op)
			4'h0: begin
				m_cross_idx[ln] = '0;
				m_auto_idx[ln]  = '0;
			end
			4'h2: if (HAS_LEDS != 0) m_leds[ln][4 * int'(ex) +: 4] = p;
			4'h4, 4'h5, 4'h6, 4'h7: begin
				if (!ex) begin
					if (p[3]) m_auto_idx[ln][slot +: 3] = p[2:0];
					else m_cross_idx[ln][slot +: 3] = p[2:0];
				end else if (m_test[ln][7]) begin
					if (p[3]) m_auto_inc[ln][slot +: 3] = p[2:0];
					else m_cross_inc[ln][slot +: 3] = p[2:0];
				end else begin
					if (p[3]) m_auto_len[ln][slot +: 3] = p[2:0];
					else m_cross_len[ln][slot +: 3] = p[2:0];
				end
			end
			4'h8: begin
				if (!ex) begin
					if (p[3]) m_auto_idx[ln][hb +: 2] = p[1:0];
					else m_cross_idx[ln][hb +: 2] = p[1:0];
				end else begin
					if (p[3]) m_auto_len[ln][hb +: 2] = p[1:0];
					else m_cross_len[ln][hb +: 2] = p[1:0];
				end
			end
			4'h9: m_voltage[ln][2 * int'(p[3:2]) +: 2] = p[1:0];
			4'hC: m_test[ln][4 * int'(ex) +: 4] = p;
			default: ;
		endcase
	endtask

	// Line writes see the line and flag from before the byte
	task automatic model_byte(input logic [7:0] b);
		logic [3:0] op;
		logic [3:0] p;
		op = b[3:0];
		p = b[7:4];
		if (int'(m_line) < NUM_LINES)
			model_line_write(int'(m_line), op, p, m_extra);
		case (op)
			4'h1: m_line[2 * int'(p[3:2]) +: 2] = p[1:0];
			4'h3: begin
				if (p[3]) m_order[2 * int'(p[2]) +: 2] = p[1:0];
				else m_baud = p[2:0];
			end
			4'hD: begin
				m_integ   = p[0];
				m_ext_clk = p[1];
				m_ts_rst  = p[2];
				m_extra   = p[3];
			end
			default: ;
		endcase
	endtask

	task automatic compare_globals();
		check_eq(32'(current_line), 32'(m_line), "current_line");
		check_eq(32'(baud_rate), 32'(m_baud), "baud_rate");
		check_eq(32'(order), 32'(m_order), "order");
		check_eq(32'(integrating), 32'(m_integ), "integrating");
		check_eq(32'(external_clock), 32'(m_ext_clk), "external_clock");
		check_eq(32'(timestamp_reset), 32'(m_ts_rst), "timestamp_reset");
		check_eq(32'(extra_commands), 32'(m_extra), "extra_commands");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	// A byte driven now reaches the global registers two edges later
	task automatic step(input logic valid, input logic [7:0] b);
		@(posedge clk);
		#1;
		if (pend_valid[1])
			model_byte(pend_byte[1]);
		compare_globals();
		pend_valid[1] = pend_valid[0];
		pend_byte[1]  = pend_byte[0];
		pend_valid[0] = valid;
		pend_byte[0]  = b;
		cmd_valid = valid;
		cmd = b;
	endtask

	task automatic idle(input int n);
		repeat (n) step(1'b0, 8'h00);
	endtask

	task automatic set_line(input int l);
		for (int s = 0; s < 4; s++)
			step(1'b1, {2'(s), 2'(l >> (2 * s)), 4'h1});
	endtask

	function automatic logic [3:0] line_op(input int k);
		case (k)
			0: return 4'h0;
			1: return 4'h2;
			2: return 4'h4;
			3: return 4'h5;
			4: return 4'h6;
			5: return 4'h7;
			6: return 4'h8;
			7: return 4'h9;
			default: return 4'hC;
		endcase
	endfunction

	task automatic random_stream(input int count, input logic line_ops_only);
		logic [7:0] b;
		logic       v;
		for (int i = 0; i < count; i++) begin
			b = 8'($urandom);
			v = ($urandom % 4) != 0;
			if (line_ops_only)
				b[3:0] = line_op(int'($urandom % 9));
			else if (b[3:0] == 4'h1 && b[7:6] != 2'b00 && ($urandom % 4) != 0)
				b[5:4] = 2'b00; // Keeps the line in range most of the time
			step(v, b);
		end
	endtask

	task automatic check_record(input int l);
		read_line = 8'(l);
		idle(3);
		check_eq(32'(rd_voltage), 32'(m_voltage[l]), $sformatf("line %0d voltage", l));
		check_eq(32'(rd_test), 32'(m_test[l]), $sformatf("line %0d test", l));
		check_eq(32'(rd_leds), 32'(m_leds[l]), $sformatf("line %0d leds", l));
		check_eq(32'(rd_cross_idx), 32'(m_cross_idx[l]), $sformatf("line %0d cross_idx", l));
		check_eq(32'(rd_auto_idx), 32'(m_auto_idx[l]), $sformatf("line %0d auto_idx", l));
		check_eq(32'(rd_cross_len), 32'(m_cross_len[l]), $sformatf("line %0d cross_len", l));
		check_eq(32'(rd_auto_len), 32'(m_auto_len[l]), $sformatf("line %0d auto_len", l));
		check_eq(32'(rd_cross_inc), 32'(m_cross_inc[l]), $sformatf("line %0d cross_inc", l));
		check_eq(32'(rd_auto_inc), 32'(m_auto_inc[l]), $sformatf("line %0d auto_inc", l));
	endtask

	task automatic sweep_records();
		idle(4);
		for (int l = 0; l < NUM_LINES; l++)
			check_record(l);
	endtask

	task automatic report(input string name);
		if (errors == errs_at_start)
			$display("%s: passed", name);
		else
			$display("%s: %0d mismatches", name, errors - errs_at_start);
		errs_at_start = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic delay_select_test();
		logic [19:0] cross_len_q;
		logic [19:0] auto_len_q;
		logic [11:0] cross_inc_q;
		logic [11:0] auto_inc_q;
		set_line(2);
		step(1'b1, 8'h8D); // Extra on, other capture flags off
		step(1'b1, 8'h8C); // Test bit 7 set
		sweep_records();
		cross_len_q = m_cross_len[2];
		auto_len_q = m_auto_len[2];
		step(1'b1, 8'h55);
		step(1'b1, 8'hB6);
		sweep_records();
		check_record(2);
		check_eq(32'(rd_cross_inc[5:3]), 32'd5, "cross_inc slot 1");
		check_eq(32'(rd_auto_inc[8:6]), 32'd3, "auto_inc slot 2");
		check_eq(32'(rd_cross_len), 32'(cross_len_q), "cross_len kept");
		check_eq(32'(rd_auto_len), 32'(auto_len_q), "auto_len kept");
		step(1'b1, 8'h0C); // Test bit 7 clear
		sweep_records();
		cross_inc_q = m_cross_inc[2];
		auto_inc_q = m_auto_inc[2];
		step(1'b1, 8'h67);
		step(1'b1, 8'hF4);
		sweep_records();
		check_record(2);
		check_eq(32'(rd_cross_len[11:9]), 32'd6, "cross_len slot 3");
		check_eq(32'(rd_auto_len[2:0]), 32'd7, "auto_len slot 0");
		check_eq(32'(rd_cross_inc), 32'(cross_inc_q), "cross_inc kept");
		check_eq(32'(rd_auto_inc), 32'(auto_inc_q), "auto_inc kept");
		step(1'b1, 8'h0D); // Extra off
		step(1'b1, 8'h74);
		step(1'b1, 8'hF8);
		sweep_records();
		step(1'b1, 8'h00);
		sweep_records();
		check_record(2);
		check_eq(32'(rd_cross_idx), 32'd0, "cross_idx cleared");
		check_eq(32'(rd_auto_idx), 32'd0, "auto_idx cleared");
	endtask

	task automatic pwm_test();
		int volts [NUM_LINES];
		int high_cnt [NUM_LINES];
		for (int l = 0; l < NUM_LINES; l++) begin
			volts[l] = (l == 0) ? 0 : (l == 1) ? 255 : int'($urandom % 256);
			high_cnt[l] = 0;
			set_line(l);
			for (int s = 0; s < 4; s++)
				step(1'b1, {2'(s), 2'(volts[l] >> (2 * s)), 4'h9});
		end
		idle(4);
		repeat (256) begin
			step(1'b0, 8'h00);
			for (int l = 0; l < NUM_LINES; l++)
				high_cnt[l] += int'(pwm_out[l]);
		end
		for (int l = 0; l < NUM_LINES; l++)
			check_eq(high_cnt[l], volts[l], $sformatf("line %0d pwm high cycles", l));
	endtask

	task automatic settings_test();
		for (int p = 0; p < 16; p++) begin
			step(1'b1, {4'(p), 4'hD});
			idle(2);
			check_eq(32'(integrating), 32'(p & 1), "integrating flag");
			check_eq(32'(external_clock), 32'((p >> 1) & 1), "external_clock flag");
			check_eq(32'(timestamp_reset), 32'((p >> 2) & 1), "timestamp_reset flag");
			check_eq(32'(extra_commands), 32'((p >> 3) & 1), "extra_commands flag");
		end
		for (int v = 0; v < 8; v++) begin
			step(1'b1, {1'b0, 3'(v), 4'h3});
			idle(2);
			check_eq(32'(baud_rate), v, "baud_rate");
		end
		for (int s = 0; s < 2; s++) begin
			for (int v = 0; v < 4; v++) begin
				step(1'b1, {1'b1, 1'(s), 2'(v), 4'h3});
				idle(2);
				check_eq(32'((order >> (2 * s)) & 4'h3), v, $sformatf("order slice %0d", s));
				check_eq(32'(baud_rate), 32'd7, "baud_rate kept");
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		cmd = 8'h00;
		cmd_valid = 1'b0;
		read_line = 8'h00;
		errors = 0;
		checks_done = 0;
		errs_at_start = 0;
		cycle_count = 0;
		pend_valid = '0;
		pend_byte[0] = 8'h00;
		pend_byte[1] = 8'h00;
		void'($urandom(SEED));
		model_reset();
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;

		sweep_records();
		check_eq(32'(pwm_out), 32'd0, "pwm_out after reset");
		report("Test 1 reset values");

		random_stream(2000, 1'b0);
		sweep_records();
		report("Test 2 random command stream");

		step(1'b1, 8'h91); // Line bit 4 set
		random_stream(30, 1'b1);
		set_line(255);
		random_stream(30, 1'b1);
		set_line(0);
		sweep_records();
		report("Test 3 lines out of range");

		delay_select_test();
		report("Test 4 delay register select");

		pwm_test();
		report("Test 5 PWM duty");

		settings_test();
		report("Test 6 capture flags and baud");

		$display("Checks run: %0d, mismatches: %0d", checks_done, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src/corr_ctrl.sv */
// Correlator control top level
`default_nettype none

module corr_ctrl #(
	parameter int NUM_LINES = 4,
	parameter int HAS_LEDS  = 1
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [cmd_pkg::CMD_W-1:0]   cmd,
	input  logic                        cmd_valid,
	input  logic [line_pkg::LINE_W-1:0] read_line,
	output logic [line_pkg::LINE_W-1:0] current_line,
	output logic [2:0]                  baud_rate,
	output logic [3:0]                  order,
	output logic                        integrating,
	output logic                        external_clock,
	output logic                        timestamp_reset,
	output logic                        extra_commands,
	output logic [NUM_LINES-1:0]        pwm_out,
	output logic [line_pkg::LVL_W-1:0]  rd_voltage,
	output logic [line_pkg::LVL_W-1:0]  rd_test,
	output logic [line_pkg::LVL_W-1:0]  rd_leds,
	output logic [line_pkg::IDX_W-1:0]  rd_cross_idx,
	output logic [line_pkg::IDX_W-1:0]  rd_auto_idx,
	output logic [line_pkg::IDX_W-1:0]  rd_cross_len,
	output logic [line_pkg::IDX_W-1:0]  rd_auto_len,
	output logic [line_pkg::INC_W-1:0]  rd_cross_inc,
	output logic [line_pkg::INC_W-1:0]  rd_auto_inc
);
	import line_pkg::*;

	logic [LVL_W-1:0]     voltage [NUM_LINES];
	logic [LVL_W-1:0]     test [NUM_LINES];
	logic [LVL_W-1:0]     leds [NUM_LINES];
	logic [NUM_LINES-1:0] test_msb;
	logic [IDX_W-1:0]     cross_idx [NUM_LINES];
	logic [IDX_W-1:0]     auto_idx [NUM_LINES];
	logic [IDX_W-1:0]     cross_len [NUM_LINES];
	logic [IDX_W-1:0]     auto_len [NUM_LINES];
	logic [INC_W-1:0]     cross_inc [NUM_LINES];
	logic [INC_W-1:0]     auto_inc [NUM_LINES];

	cfg_wr_if #(.NUM_LINES(NUM_LINES)) wr_bus ();

	cmd_parser #(.NUM_LINES(NUM_LINES)) u_parser (
		.clk             (clk),
		.rst_n           (rst_n),
		.cmd             (cmd),
		.cmd_valid       (cmd_valid),
		.wr              (wr_bus.src),
		.current_line    (current_line),
		.baud_rate       (baud_rate),
		.order           (order),
		.integrating     (integrating),
		.external_clock  (external_clock),
		.timestamp_reset (timestamp_reset),
		.extra_commands  (extra_commands)
	);

	level_bank #(.NUM_LINES(NUM_LINES), .HAS_LEDS(HAS_LEDS)) u_level (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr       (wr_bus.dst),
		.voltage  (voltage),
		.test     (test),
		.leds     (leds),
		.test_msb (test_msb),
		.pwm_out  (pwm_out)
	);

	delay_bank #(.NUM_LINES(NUM_LINES)) u_delay (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr        (wr_bus.dst),
		.test_msb  (test_msb),
		.cross_idx (cross_idx),
		.auto_idx  (auto_idx),
		.cross_len (cross_len),
		.auto_len  (auto_len),
		.cross_inc (cross_inc),
		.auto_inc  (auto_inc)
	);

	line_readback #(.NUM_LINES(NUM_LINES)) u_readback (
		.clk          (clk),
		.rst_n        (rst_n),
		.read_line    (read_line),
		.voltage      (voltage),
		.test         (test),
		.leds         (leds),
		.cross_idx    (cross_idx),
		.auto_idx     (auto_idx),
		.cross_len    (cross_len),
		.auto_len     (auto_len),
		.cross_inc    (cross_inc),
		.auto_inc     (auto_inc),
		.rd_voltage   (rd_voltage),
		.rd_test      (rd_test),
		.rd_leds      (rd_leds),
		.rd_cross_idx (rd_cross_idx),
		.rd_auto_idx  (rd_auto_idx),
		.rd_cross_len (rd_cross_len),
		.rd_auto_len  (rd_auto_len),
		.rd_cross_inc (rd_cross_inc),
		.rd_auto_inc  (rd_auto_inc)
	);

endmodule

`default_nettype wire

/* src/line_readback.sv */
// Line record readback
`default_nettype none

module line_readback #(
	parameter int NUM_LINES = 4
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [line_pkg::LINE_W-1:0] read_line,
	input  logic [line_pkg::LVL_W-1:0]  voltage [NUM_LINES],
	input  logic [line_pkg::LVL_W-1:0]  test [NUM_LINES],
	input  logic [line_pkg::LVL_W-1:0]  leds [NUM_LINES],
	input  logic [line_pkg::IDX_W-1:0]  cross_idx [NUM_LINES],
	input  logic [line_pkg::IDX_W-1:0]  auto_idx [NUM_LINES],
	input  logic [line_pkg::IDX_W-1:0]  cross_len [NUM_LINES],
	input  logic [line_pkg::IDX_W-1:0]  auto_len [NUM_LINES],
	input  logic [line_pkg::INC_W-1:0]  cross_inc [NUM_LINES],
	input  logic [line_pkg::INC_W-1:0]  auto_inc [NUM_LINES],
	output logic [line_pkg::LVL_W-1:0]  rd_voltage,
	output logic [line_pkg::LVL_W-1:0]  rd_test,
	output logic [line_pkg::LVL_W-1:0]  rd_leds,
	output logic [line_pkg::IDX_W-1:0]  rd_cross_idx,
	output logic [line_pkg::IDX_W-1:0]  rd_auto_idx,
	output logic [line_pkg::IDX_W-1:0]  rd_cross_len,
	output logic [line_pkg::IDX_W-1:0]  rd_auto_len,
	output logic [line_pkg::INC_W-1:0]  rd_cross_inc,
	output logic [line_pkg::INC_W-1:0]  rd_auto_inc
);
	import line_pkg::*;

	localparam int LINE_SEL_W = line_sel_w(NUM_LINES);

	logic                  in_range;
	logic [LINE_SEL_W-1:0] sel;

	assign in_range = read_line < LINE_W'(NUM_LINES);
	assign sel      = read_line[LINE_SEL_W-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n || !in_range) begin // Missing lines read as zeros
			rd_voltage   <= '0;
			rd_test      <= '0;
			rd_leds      <= '0;
			rd_cross_idx <= '0;
			rd_auto_idx  <= '0;
			rd_cross_len <= '0;
			rd_auto_len  <= '0;
			rd_cross_inc <= '0;
			rd_auto_inc  <= '0;
		end else begin
			rd_voltage   <= voltage[sel];
			rd_test      <= test[sel];
			rd_leds      <= leds[sel];
			rd_cross_idx <= cross_idx[sel];
			rd_auto_idx  <= auto_idx[sel];
			rd_cross_len <= cross_len[sel];
			rd_auto_len  <= auto_len[sel];
			rd_cross_inc <= cross_inc[sel];
			rd_auto_inc  <= auto_inc[sel];
		end
	end

endmodule

`default_nettype wire

/* src/delay_bank.sv */
// Line delay registers
`default_nettype none

module delay_bank #(
	parameter int NUM_LINES = 4
) (
	input  logic                       clk,
	input  logic                       rst_n,
	cfg_wr_if.dst                      wr,
	input  logic [NUM_LINES-1:0]       test_msb,
	output logic [line_pkg::IDX_W-1:0] cross_idx [NUM_LINES],
	output logic [line_pkg::IDX_W-1:0] auto_idx [NUM_LINES],
	output logic [line_pkg::IDX_W-1:0] cross_len [NUM_LINES],
	output logic [line_pkg::IDX_W-1:0] auto_len [NUM_LINES],
	output logic [line_pkg::INC_W-1:0] cross_inc [NUM_LINES],
	output logic [line_pkg::INC_W-1:0] auto_inc [NUM_LINES]
);
	import cmd_pkg::*;
	import line_pkg::*;

	logic [3:0] slot_lsb;
	logic [4:0] div_lsb;
	logic [2:0] slot_val;
	logic [1:0] div_val;
	logic       to_inc;

	assign slot_lsb = 4'(wr.sel) * 4'd3;              // Four 3-bit slots in the low 12 bits
	assign div_lsb  = wr.data[2] ? 5'd14 : 5'd12;
	assign slot_val = wr.data[2:0];
	assign div_val  = wr.data[1:0];
	assign to_inc   = test_msb[wr.line];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_LINES; i++) begin
				cross_idx[i] <= '0;
				auto_idx[i]  <= '0;
				cross_len[i] <= '0;
				auto_len[i]  <= '0;
				cross_inc[i] <= INC_W'(INC_RST);
				auto_inc[i]  <= INC_W'(INC_RST);
			end
		end else if (wr.wr) begin
			case (wr.op)
				CLEAR: begin
					cross_idx[wr.line] <= '0;
					auto_idx[wr.line]  <= '0;
				end
				SET_DELAY: begin
					if (!wr.extra) begin
						if (wr.auto_sel)
							auto_idx[wr.line][slot_lsb +: 3] <= slot_val;
						else
							cross_idx[wr.line][slot_lsb +: 3] <= slot_val;
					end else if (to_inc) begin
						if (wr.auto_sel)
							auto_inc[wr.line][slot_lsb +: 3] <= slot_val;
						else
							cross_inc[wr.line][slot_lsb +: 3] <= slot_val;
					end else begin
						if (wr.auto_sel)
							auto_len[wr.line][slot_lsb +: 3] <= slot_val;
						else
							cross_len[wr.line][slot_lsb +: 3] <= slot_val;
					end
				end
				SET_FREQ_DIV: begin
					// Upper bits of index or length, never the increment
					if (!wr.extra) begin
						if (wr.auto_sel)
							auto_idx[wr.line][div_lsb +: 2] <= div_val;
						else
							cross_idx[wr.line][div_lsb +: 2] <= div_val;
					end else begin
						if (wr.auto_sel)
							auto_len[wr.line][div_lsb +: 2] <= div_val;
						else
							cross_len[wr.line][div_lsb +: 2] <= div_val;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/level_bank.sv */
// Line level registers and PWM
`default_nettype none

module level_bank #(
	parameter int NUM_LINES = 4,
	parameter int HAS_LEDS  = 1
) (
	input  logic                       clk,
	input  logic                       rst_n,
	cfg_wr_if.dst                      wr,
	output logic [line_pkg::LVL_W-1:0] voltage [NUM_LINES],
	output logic [line_pkg::LVL_W-1:0] test [NUM_LINES],
	output logic [line_pkg::LVL_W-1:0] leds [NUM_LINES],
	output logic [NUM_LINES-1:0]       test_msb,
	output logic [NUM_LINES-1:0]       pwm_out
);
	import cmd_pkg::*;
	import line_pkg::*;

	logic [LVL_W-1:0] pwm_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_LINES; i++) begin
				voltage[i] <= '0;
				test[i]    <= '0;
			end
		end else if (wr.wr) begin
			case (wr.op)
				SET_VOLTAGE: voltage[wr.line][{wr.data[3:2], 1'b0} +: 2] <= wr.data[1:0];
				ENABLE_TEST: test[wr.line][{wr.extra, 2'b00} +: 4] <= wr.data;
				default: ;
			endcase
		end
	end

	generate
		if (HAS_LEDS != 0) begin : g_leds
			always_ff @(posedge clk) begin
				if (!rst_n) begin
					for (int i = 0; i < NUM_LINES; i++)
						leds[i] <= '0;
				end else if (wr.wr && wr.op == SET_LEDS) begin
					leds[wr.line][{wr.extra, 2'b00} +: 4] <= wr.data; // Extra picks the high nibble
				end
			end
		end else begin : g_no_leds
			always_comb begin
				for (int i = 0; i < NUM_LINES; i++)
					leds[i] = '0;
			end
		end
	endgenerate

	always_comb begin
		for (int i = 0; i < NUM_LINES; i++)
			test_msb[i] = test[i][LVL_W-1];
	end

	////////////////////////////////////////////////////////////////////////////
	// PWM

	always_ff @(posedge clk) begin
		if (!rst_n)
			pwm_cnt <= '0;
		else
			pwm_cnt <= pwm_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pwm_out <= '0;
		else
			for (int i = 0; i < NUM_LINES; i++)
				pwm_out[i] <= pwm_cnt < voltage[i]; // High for voltage counts per period
	end

endmodule

`default_nettype wire

/* src/cmd_parser.sv */
// Command parser
`default_nettype none

module cmd_parser #(
	parameter int NUM_LINES = 4
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [cmd_pkg::CMD_W-1:0]   cmd,
	input  logic                        cmd_valid,
	cfg_wr_if.src                       wr,
	output logic [line_pkg::LINE_W-1:0] current_line,
	output logic [2:0]                  baud_rate,
	output logic [3:0]                  order,
	output logic                        integrating,
	output logic                        external_clock,
	output logic                        timestamp_reset,
	output logic                        extra_commands
);
	import cmd_pkg::*;
	import line_pkg::*;

	localparam int LINE_SEL_W = line_sel_w(NUM_LINES);

	cmd_byte_t cmd_q;
	logic      valid_q;
	cmd_op_e   op;
	logic      line_ok;

	////////////////////////////////////////////////////////////////////////////
	// Input capture

	always_ff @(posedge clk) begin
		cmd_q <= cmd;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= cmd_valid;
	end

	assign op = decode_op(cmd_q.opcode);
	assign line_ok = current_line < LINE_W'(NUM_LINES);

	////////////////////////////////////////////////////////////////////////////
	// Global settings

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			current_line    <= '0;
			baud_rate       <= '0;
			order           <= '0;
			integrating     <= 1'b0;
			external_clock  <= 1'b0;
			timestamp_reset <= 1'b1;
			extra_commands  <= 1'b0;
		end else if (valid_q) begin
			case (op)
				SET_LINE: current_line[{cmd_q.payload[3:2], 1'b0} +: 2] <= cmd_q.payload[1:0];
				SET_BAUD: begin
					if (cmd_q.payload[3])
						order[{cmd_q.payload[2], 1'b0} +: 2] <= cmd_q.payload[1:0];
					else
						baud_rate <= cmd_q.payload[2:0];
				end
				ENABLE_CAPTURE: begin
					integrating     <= cmd_q.payload[0];
					external_clock  <= cmd_q.payload[1];
					timestamp_reset <= cmd_q.payload[2];
					extra_commands  <= cmd_q.payload[3];
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Line write issue

	always_ff @(posedge clk) begin
		if (!rst_n)
			wr.wr <= 1'b0;
		else
			wr.wr <= valid_q && is_line_op(op) && line_ok; // Out of range lines die here
	end

	// Line and flag are sampled before this byte can change them
	always_ff @(posedge clk) begin
		wr.op       <= op;
		wr.line     <= current_line[LINE_SEL_W-1:0];
		wr.sel      <= cmd_q.opcode[1:0];
		wr.data     <= cmd_q.payload;
		wr.extra    <= extra_commands;
		wr.auto_sel <= cmd_q.payload[3];
	end

endmodule

`default_nettype wire

/* src/cfg_wr_if.sv */
// Line write bus
`default_nettype none

interface cfg_wr_if #(
	parameter int NUM_LINES = 4
);
	import cmd_pkg::*;
	import line_pkg::*;

	localparam int SEL_W = line_sel_w(NUM_LINES);

	logic                 wr;       // One-cycle write strobe
	cmd_op_e              op;
	logic [SEL_W-1:0]     line;     // Always below NUM_LINES when wr is high
	logic [1:0]           sel;
	logic [PAYLOAD_W-1:0] data;
	logic                 extra;
	logic                 auto_sel;

	modport src (
		output wr, op, line, sel, data, extra, auto_sel
	);

	modport dst (
		input wr, op, line, sel, data, extra, auto_sel
	);

endinterface

`default_nettype wire

/* src/line_pkg.sv */
// Per-line register layout
`default_nettype none

package line_pkg;

	localparam int LINE_W = 8;
	localparam int IDX_W = 20;
	localparam int INC_W = 12;
	localparam int LVL_W = 8;

	localparam int INC_RST = 1;

	// Bits needed to address one of num_lines lines
	function automatic int line_sel_w(input int num_lines);
		return (num_lines > 1) ? $clog2(num_lines) : 1;
	endfunction

endpackage

`default_nettype wire

/* src/cmd_pkg.sv */
// Command byte definitions
`default_nettype none

package cmd_pkg;

	localparam int CMD_W = 8;
	localparam int OP_W = 4;
	localparam int PAYLOAD_W = CMD_W - OP_W;

	typedef enum logic [OP_W-1:0] {
		CLEAR          = 4'd0,
		SET_LINE       = 4'd1,
		SET_LEDS       = 4'd2,
		SET_BAUD       = 4'd3,
		SET_DELAY      = 4'd4,
		SET_FREQ_DIV   = 4'd8,
		SET_VOLTAGE    = 4'd9,
		ENABLE_TEST    = 4'd12,
		ENABLE_CAPTURE = 4'd13,
		NOP            = 4'd15
	} cmd_op_e;

	// Payload rides in the high nibble, opcode in the low one
	typedef struct packed {
		logic [PAYLOAD_W-1:0] payload;
		logic [OP_W-1:0]      opcode;
	} cmd_byte_t;

	function automatic cmd_op_e decode_op(input logic [OP_W-1:0] code);
		cmd_op_e op;
		case (code)
			4'd0:                   op = CLEAR;
			4'd1:                   op = SET_LINE;
			4'd2:                   op = SET_LEDS;
			4'd3:                   op = SET_BAUD;
			4'd4, 4'd5, 4'd6, 4'd7: op = SET_DELAY; // Low bits carry the slot
			4'd8:                   op = SET_FREQ_DIV;
			4'd9:                   op = SET_VOLTAGE;
			4'd12:                  op = ENABLE_TEST;
			4'd13:                  op = ENABLE_CAPTURE;
			default:                op = NOP;
		endcase
		return op;
	endfunction

	// Opcodes that touch a per-line register
	function automatic logic is_line_op(input cmd_op_e op);
		return op inside {CLEAR, SET_LEDS, SET_DELAY, SET_FREQ_DIV, SET_VOLTAGE, ENABLE_TEST};
	endfunction

endpackage

`default_nettype wire
